/* build.f */
logic/ucode_pkg.sv
logic/uop_if.sv
logic/instr_queue.sv
logic/microcode_rom.sv
logic/microcode_sequencer.sv
logic/uop_execute.sv
logic/ucode_core.sv
tests/ucode_core_tb.sv
tests/ucode_core_assert.sv

/* logic/instr_queue.sv */
//******************************
// four-entry instruction queue
// credit back to the sender on each pop
//******************************
`timescale 1ns/1ps

module instr_queue (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            in_valid,
    input  logic [ucode_pkg::OP_BITS-1:0]   in_opcode,
    input  logic [ucode_pkg::REG_BITS-1:0]  in_rd,
    input  logic [ucode_pkg::DATA_BITS-1:0] in_imm,
    output logic                            in_credit,
    output ucode_pkg::instr_t               head,
    output logic                            empty,
    input  logic                            pop
);
    import ucode_pkg::*;

    instr_t                 entries [QUEUE_DEPTH];
    instr_t                 incoming;
    logic [QPTR_BITS-1:0]   wr_ptr;
    logic [QPTR_BITS-1:0]   rd_ptr;
    logic [QCOUNT_BITS-1:0] count;

    function automatic logic known_op(logic [OP_BITS-1:0] op);
        return op inside {OP_LDI, OP_ADDI, OP_XORI, OP_SHLN, OP_SUMDN};
    endfunction

    // opcodes outside the enum are flagged here, the sequencer traps them
    always_comb begin
        incoming.opcode  = instr_op_e'(in_opcode);
        incoming.rd      = in_rd;
        incoming.imm     = in_imm;
        incoming.invalid = !known_op(in_opcode);
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            entries[wr_ptr] <= incoming;
        end
    end

    // no full check, the sender never holds more credits than free slots
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (in_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({in_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign head      = entries[rd_ptr];
    assign empty     = count == '0;
    assign in_credit = pop;

endmodule

/* logic/microcode_rom.sv */
//******************************
// microcode store, constant table
// with registered read
//******************************
`timescale 1ns/1ps

module microcode_rom (
    input  logic                             clk,
    input  logic [ucode_pkg::UADDR_BITS-1:0] addr,
    output ucode_pkg::uinstr_t               data
);
    import ucode_pkg::*;

    // word that only steers the sequencer
    function automatic uinstr_t ctl_word(jump_type_e jump, logic [UADDR_BITS-1:0] nxt,
                                         logic load, logic ack);
        return '{next: nxt, jump_type: jump, alu_op: ALU_PASS_B, a_sel: A_RD,
                 b_sel: B_ZERO, dest: A_RD, wr_en: 1'b0, load_loop: load, int_ack: ack};
    endfunction

    // word that issues one micro-op
    function automatic uinstr_t alu_word(jump_type_e jump, logic [UADDR_BITS-1:0] nxt,
                                         alu_op_e op, a_sel_e a, b_sel_e b, a_sel_e d);
        return '{next: nxt, jump_type: jump, alu_op: op, a_sel: a, b_sel: b,
                 dest: d, wr_en: 1'b1, load_loop: 1'b0, int_ack: 1'b0};
    endfunction

    function automatic uinstr_t rom_word(logic [UADDR_BITS-1:0] a);
        case (a)
            FETCH_ADDR:  return ctl_word(JUMP_DISPATCH, FETCH_ADDR, 1'b0, 1'b1);
            RESET_ADDR:  return ctl_word(JUMP_UNCOND, FETCH_ADDR, 1'b0, 1'b0);
            // ldi, addi, xori
            8:  return alu_word(JUMP_END, FETCH_ADDR, ALU_PASS_B, A_RD, B_IMM, A_RD);
            16: return alu_word(JUMP_END, FETCH_ADDR, ALU_ADD, A_RD, B_IMM, A_RD);
            24: return alu_word(JUMP_END, FETCH_ADDR, ALU_XOR, A_RD, B_IMM, A_RD);
            // shln, loop count from imm[3:0]
            32: return ctl_word(JUMP_NEXT, FETCH_ADDR, 1'b1, 1'b0);
            33: return ctl_word(JUMP_LOOP_DONE, UADDR_BITS'(35), 1'b0, 1'b0);
            34: return alu_word(JUMP_UNCOND, UADDR_BITS'(33), ALU_SHL1, A_RD, B_ZERO, A_RD);
            35: return ctl_word(JUMP_END, FETCH_ADDR, 1'b0, 1'b0);
            // sumdn, first word rewrites rd unchanged to set zf
            40: return alu_word(JUMP_NEXT, FETCH_ADDR, ALU_ADD, A_RD, B_ZERO, A_RD);
            41: return ctl_word(JUMP_ZERO, UADDR_BITS'(44), 1'b0, 1'b0);
            42: return alu_word(JUMP_NEXT, FETCH_ADDR, ALU_ADD, A_R0, B_RD, A_R0);
            43: return alu_word(JUMP_UNCOND, UADDR_BITS'(41), ALU_SUB, A_RD, B_ONE, A_RD);
            44: return ctl_word(JUMP_END, FETCH_ADDR, 1'b0, 1'b0);
            // interrupt service counts in r6
            IRQ_ADDR:    return alu_word(JUMP_NEXT, FETCH_ADDR, ALU_ADD, A_R6, B_ONE, A_R6);
            49:          return ctl_word(JUMP_END, FETCH_ADDR, 1'b0, 1'b0);
            // invalid opcodes count in r7
            BAD_OP_ADDR: return alu_word(JUMP_END, FETCH_ADDR, ALU_ADD, A_R7, B_ONE, A_R7);
            default:     return ctl_word(JUMP_END, FETCH_ADDR, 1'b0, 1'b0);
        endcase
    endfunction

    always_ff @(posedge clk) begin
        data <= rom_word(addr);
    end

endmodule

/* logic/microcode_sequencer.sv */
//******************************
// microcode sequencer: next-address chain, dispatch,
// loop counter, interrupt and bad-opcode entry, uop credits
//******************************
`timescale 1ns/1ps

module microcode_sequencer (
    input  logic              clk,
    input  logic              reset,
    input  ucode_pkg::instr_t head,
    input  logic              empty,
    output logic              pop,
    input  logic              intr,
    output logic              inta,
    input  logic              zf,
    uop_if.seq                uop
);
    import ucode_pkg::*;

    logic [UADDR_BITS-1:0]  addr;
    logic [UADDR_BITS-1:0]  next_addr;
    uinstr_t                current;
    instr_t                 cur_instr;
    logic [LOOP_BITS-1:0]   loop_cnt;
    logic [CREDIT_BITS-1:0] credits;
    logic                   loop_done;
    logic                   dispatching;
    logic                   drained;
    logic                   take_irq;
    logic                   stall;
    logic                   issue;

    microcode_rom rom_i (
        .clk  (clk),
        .addr (next_addr),
        .data (current)
    );

    assign dispatching = current.jump_type == JUMP_DISPATCH;
    assign take_irq    = intr && current.int_ack;
    assign loop_done   = loop_cnt == '0;
    // nothing in flight, so zf belongs to the last issued op
    assign drained     = credits == CREDIT_BITS'(UOP_DEPTH);

    assign stall = (current.wr_en && credits == '0) ||
                   (current.jump_type == JUMP_ZERO && !drained) ||
                   (dispatching && empty && !take_irq);

    assign issue = current.wr_en && !stall;
    // interrupt wins over a waiting instruction
    assign pop   = dispatching && !empty && !take_irq;

    always_comb begin
        if (reset) begin
            next_addr = RESET_ADDR;
        end else if (stall) begin
            next_addr = addr;
        end else if (take_irq) begin
            next_addr = IRQ_ADDR;
        end else begin
            case (current.jump_type)
                JUMP_DISPATCH: begin
                    if (head.invalid) begin
                        next_addr = BAD_OP_ADDR;
                    end else begin
                        next_addr = UADDR_BITS'({head.opcode[2:0], 3'b000});
                    end
                end
                JUMP_ZERO:      next_addr = zf ? current.next : addr + 1'b1;
                JUMP_LOOP_DONE: next_addr = loop_done ? current.next : addr + 1'b1;
                JUMP_END:       next_addr = FETCH_ADDR;
                JUMP_UNCOND:    next_addr = current.next;
                default:        next_addr = addr + 1'b1;
            endcase
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            addr <= RESET_ADDR;
        end else begin
            addr <= next_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            cur_instr <= head;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            loop_cnt <= '0;
            credits  <= CREDIT_BITS'(UOP_DEPTH);
            inta     <= 1'b0;
        end else begin
            inta <= take_irq;
            if (!stall && current.load_loop) begin
                loop_cnt <= cur_instr.imm[LOOP_BITS-1:0];
            end else if (!stall && current.jump_type == JUMP_LOOP_DONE && !loop_done) begin
                loop_cnt <= loop_cnt - 1'b1;
            end
            case ({issue, uop.credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    assign uop.valid  = issue;
    assign uop.alu_op = current.alu_op;
    assign uop.a_sel  = current.a_sel;
    assign uop.b_sel  = current.b_sel;
    assign uop.dest   = current.dest;
    assign uop.rd     = cur_instr.rd;
    assign uop.imm    = cur_instr.imm;

endmodule

/* logic/ucode_core.sv */
//******************************
// top level: instruction queue,
// microcode sequencer and execute stage
//******************************
`timescale 1ns/1ps

module ucode_core (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            in_valid,
    input  logic [ucode_pkg::OP_BITS-1:0]   in_opcode,
    input  logic [ucode_pkg::REG_BITS-1:0]  in_rd,
    input  logic [ucode_pkg::DATA_BITS-1:0] in_imm,
    output logic                            in_credit,
    input  logic                            intr,
    output logic                            inta,
    output logic                            wr_valid,
    output logic [ucode_pkg::REG_BITS-1:0]  wr_reg,
    output logic [ucode_pkg::DATA_BITS-1:0] wr_data
);
    import ucode_pkg::*;

    instr_t head;
    logic   empty;
    logic   pop;
    logic   zf;

    uop_if uop_ch ();

    instr_queue queue_i (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_opcode (in_opcode),
        .in_rd     (in_rd),
        .in_imm    (in_imm),
        .in_credit (in_credit),
        .head      (head),
        .empty     (empty),
        .pop       (pop)
    );

    microcode_sequencer seq_i (
        .clk   (clk),
        .reset (reset),
        .head  (head),
        .empty (empty),
        .pop   (pop),
        .intr  (intr),
        .inta  (inta),
        .zf    (zf),
        .uop   (uop_ch.seq)
    );

    uop_execute exec_i (
        .clk      (clk),
        .reset    (reset),
        .uop      (uop_ch.exec),
        .zf       (zf),
        .wr_valid (wr_valid),
        .wr_reg   (wr_reg),
        .wr_data  (wr_data)
    );

endmodule

/* logic/ucode_pkg.sv */
//******************************
// shared widths and depths, opcode, ALU-op and jump-type enums,
// instruction and microinstruction structs, fixed ROM addresses
//******************************
package ucode_pkg;

    localparam int NUM_REGS    = 8;
    localparam int REG_BITS    = 3;
    localparam int DATA_BITS   = 16;
    localparam int OP_BITS     = 8;
    localparam int QUEUE_DEPTH = 4;
    localparam int QPTR_BITS   = $clog2(QUEUE_DEPTH);
    localparam int QCOUNT_BITS = $clog2(QUEUE_DEPTH + 1);
    localparam int UOP_DEPTH   = 2;
    localparam int UPTR_BITS   = $clog2(UOP_DEPTH);
    localparam int CREDIT_BITS = $clog2(UOP_DEPTH + 1);
    localparam int UADDR_BITS  = 6;
    localparam int LOOP_BITS   = 4;

    // routines sit in 8-word slots, slot index is the opcode
    localparam logic [UADDR_BITS-1:0] FETCH_ADDR  = UADDR_BITS'(0);
    localparam logic [UADDR_BITS-1:0] RESET_ADDR  = UADDR_BITS'(1);
    localparam logic [UADDR_BITS-1:0] IRQ_ADDR    = UADDR_BITS'(48);
    localparam logic [UADDR_BITS-1:0] BAD_OP_ADDR = UADDR_BITS'(56);

    typedef enum logic [OP_BITS-1:0] {
        OP_LDI   = 8'h01,
        OP_ADDI  = 8'h02,
        OP_XORI  = 8'h03,
        OP_SHLN  = 8'h04,
        OP_SUMDN = 8'h05
    } instr_op_e;

    typedef enum logic [2:0] {
        ALU_PASS_B,
        ALU_ADD,
        ALU_SUB,
        ALU_XOR,
        ALU_SHL1
    } alu_op_e;

    typedef enum logic [2:0] {
        JUMP_NEXT,
        JUMP_UNCOND,
        JUMP_DISPATCH,
        JUMP_ZERO,
        JUMP_LOOP_DONE,
        JUMP_END
    } jump_type_e;

    typedef enum logic [1:0] {A_RD, A_R0, A_R6, A_R7} a_sel_e;

    typedef enum logic [1:0] {B_IMM, B_RD, B_ONE, B_ZERO} b_sel_e;

    typedef struct packed {
        instr_op_e             opcode;
        logic [REG_BITS-1:0]   rd;
        logic [DATA_BITS-1:0]  imm;
        logic                  invalid;
    } instr_t;

    typedef struct packed {
        logic [UADDR_BITS-1:0] next;
        jump_type_e            jump_type;
        alu_op_e               alu_op;
        a_sel_e                a_sel;
        b_sel_e                b_sel;
        a_sel_e                dest;
        logic                  wr_en;
        logic                  load_loop;
        // interrupt window, only the fetch word sets it
        logic                  int_ack;
    } uinstr_t;

endpackage

/* logic/uop_execute.sv */
//******************************
// execute stage: two-entry uop buffer,
// register file, ALU, zero flag, write report
//******************************
`timescale 1ns/1ps

module uop_execute (
    input  logic                            clk,
    input  logic                            reset,
    uop_if.exec                             uop,
    output logic                            zf,
    output logic                            wr_valid,
    output logic [ucode_pkg::REG_BITS-1:0]  wr_reg,
    output logic [ucode_pkg::DATA_BITS-1:0] wr_data
);
    import ucode_pkg::*;

    typedef struct packed {
        alu_op_e              alu_op;
        a_sel_e               a_sel;
        b_sel_e               b_sel;
        a_sel_e               dest;
        logic [REG_BITS-1:0]  rd;
        logic [DATA_BITS-1:0] imm;
    } uop_t;

    uop_t                   buf_q [UOP_DEPTH];
    logic [UPTR_BITS-1:0]   wr_ptr;
    logic [UPTR_BITS-1:0]   rd_ptr;
    logic [CREDIT_BITS-1:0] count;
    logic [DATA_BITS-1:0]   regs [NUM_REGS];
    uop_t                   oldest;
    logic                   retire;
    logic [REG_BITS-1:0]    d_idx;
    logic [DATA_BITS-1:0]   a_val;
    logic [DATA_BITS-1:0]   b_val;
    logic [DATA_BITS-1:0]   result;

    function automatic logic [REG_BITS-1:0] reg_index(a_sel_e sel, logic [REG_BITS-1:0] rd);
        case (sel)
            A_R0:    return REG_BITS'(0);
            A_R6:    return REG_BITS'(6);
            A_R7:    return REG_BITS'(7);
            default: return rd;
        endcase
    endfunction

    assign oldest = buf_q[rd_ptr];
    assign retire = count != '0;
    assign d_idx  = reg_index(oldest.dest, oldest.rd);
    assign a_val  = regs[reg_index(oldest.a_sel, oldest.rd)];

    always_comb begin
        case (oldest.b_sel)
            B_IMM:   b_val = oldest.imm;
            B_RD:    b_val = regs[oldest.rd];
            B_ONE:   b_val = DATA_BITS'(1);
            default: b_val = '0;
        endcase
        case (oldest.alu_op)
            ALU_ADD:  result = a_val + b_val;
            ALU_SUB:  result = a_val - b_val;
            ALU_XOR:  result = a_val ^ b_val;
            ALU_SHL1: result = {a_val[DATA_BITS-2:0], 1'b0};
            default:  result = b_val;
        endcase
    end

    always_ff @(posedge clk) begin
        if (uop.valid) begin
            buf_q[wr_ptr] <= '{alu_op: uop.alu_op, a_sel: uop.a_sel, b_sel: uop.b_sel,
                              dest: uop.dest, rd: uop.rd, imm: uop.imm};
        end
        if (retire) begin
            wr_reg  <= d_idx;
            wr_data <= result;
        end
    end

    // one retire per cycle, the credit goes back a cycle later
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            zf         <= 1'b0;
            wr_valid   <= 1'b0;
            uop.credit <= 1'b0;
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            wr_valid   <= retire;
            uop.credit <= retire;
            if (uop.valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (retire) begin
                rd_ptr      <= rd_ptr + 1'b1;
                regs[d_idx] <= result;
                zf          <= result == '0;
            end
            case ({uop.valid, retire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* logic/uop_if.sv */
//******************************
// micro-op channel from sequencer to execute,
// credit return in the opposite direction
//******************************
`timescale 1ns/1ps

interface uop_if;
    import ucode_pkg::*;

    logic                 valid;
    alu_op_e              alu_op;
    a_sel_e               a_sel;
    b_sel_e               b_sel;
    a_sel_e               dest;
    logic [REG_BITS-1:0]  rd;
    logic [DATA_BITS-1:0] imm;
    // one pulse per retired entry
    logic                 credit;

    modport seq (output valid, alu_op, a_sel, b_sel, dest, rd, imm, input credit);

    modport exec (input valid, alu_op, a_sel, b_sel, dest, rd, imm, output credit);

endinterface

/* tests/ucode_core_assert.sv */
//******************************
// concurrent checks on uop credits,
// interrupt acknowledge and queue pops
//******************************
`timescale 1ns/1ps

module ucode_core_assert (
    input logic                              clk,
    input logic                              reset,
    input logic [ucode_pkg::CREDIT_BITS-1:0] credits,
    input logic                              uop_valid,
    input logic                              inta,
    input logic                              pop,
    input logic                              empty
);
    import ucode_pkg::*;

    int fail_count = 0;

    credit_bound: assert property (@(posedge clk) disable iff (reset)
        credits <= CREDIT_BITS'(UOP_DEPTH))
        else begin
            $error("uop credit counter above its limit");
            fail_count++;
        end

    // an issue needs a free execute slot
    issue_has_credit: assert property (@(posedge clk) disable iff (reset)
        uop_valid |-> credits != '0)
        else begin
            $error("uop issued with zero credit");
            fail_count++;
        end

    inta_single: assert property (@(posedge clk) disable iff (reset)
        inta |=> !inta)
        else begin
            $error("inta held longer than one cycle");
            fail_count++;
        end

    pop_not_empty: assert property (@(posedge clk) disable iff (reset)
        pop |-> !empty)
        else begin
            $error("pop from an empty instruction queue");
            fail_count++;
        end

endmodule

/* tests/ucode_core_tb.sv */
//******************************
// testbench: clock and reset, credit-limited vector driver,
// interrupt requester, reference model, write checks, watchdog
//******************************
`timescale 1ns/1ps

module ucode_core_tb;
    import ucode_pkg::*;

    localparam int RESET_CYCLES   = 16;
    localparam int NUM_IRQS       = 4;
    localparam int MAX_VECS       = 64;
    localparam int ROUTINE_CYCLES = 100;
    localparam int IRQ_GAP_MAX    = 40;
    localparam int DRAIN_CYCLES   = 20;

    logic                 clk;
    logic                 reset;
    logic                 in_valid;
    logic [OP_BITS-1:0]   in_opcode;
    logic [REG_BITS-1:0]  in_rd;
    logic [DATA_BITS-1:0] in_imm;
    logic                 in_credit;
    logic                 intr;
    logic                 inta;
    logic                 wr_valid;
    logic [REG_BITS-1:0]  wr_reg;
    logic [DATA_BITS-1:0] wr_data;

    logic [31:0]                   vec_mem [1 + MAX_VECS + NUM_REGS];
    int                            num_vecs = 0;
    logic [DATA_BITS-1:0]          model [NUM_REGS];
    logic [DATA_BITS-1:0]          observed [NUM_REGS];
    logic [REG_BITS+DATA_BITS-1:0] exp_q [$];
    int                            inta_seen = 0;
    int                            irq_writes = 0;
    integer                        gap_seed = 32'h93aa46e1;
    integer                        irq_seed = 32'h93aa46e1;

    ucode_core dut_i (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_opcode (in_opcode),
        .in_rd     (in_rd),
        .in_imm    (in_imm),
        .in_credit (in_credit),
        .intr      (intr),
        .inta      (inta),
        .wr_valid  (wr_valid),
        .wr_reg    (wr_reg),
        .wr_data   (wr_data)
    );

    bind microcode_sequencer ucode_core_assert seq_assert_i (
        .clk       (clk),
        .reset     (reset),
        .credits   (credits),
        .uop_valid (uop.valid),
        .inta      (inta),
        .pop       (pop),
        .empty     (empty)
    );

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("Something failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic expect_write(input logic [REG_BITS-1:0] r, input logic [DATA_BITS-1:0] d);
        model[r] = d;
        exp_q.push_back({r, d});
    endtask

    task automatic expect_instr(input logic [OP_BITS-1:0] op, input logic [REG_BITS-1:0] rd,
                                input logic [DATA_BITS-1:0] imm);
        case (op)
            OP_LDI:  expect_write(rd, imm);
            OP_ADDI: expect_write(rd, model[rd] + imm);
            OP_XORI: expect_write(rd, model[rd] ^ imm);
            OP_SHLN: begin
                // one write per single-bit shift
                repeat (imm[3:0]) begin
                    expect_write(rd, model[rd] << 1);
                end
            end
            OP_SUMDN: begin
                // rd is rewritten once before the first zero test
                expect_write(rd, model[rd]);
                while (model[rd] != '0) begin
                    expect_write(REG_BITS'(0), model[0] + model[rd]);
                    expect_write(rd, model[rd] - 1'b1);
                end
            end
            default: expect_write(REG_BITS'(7), model[7] + 1'b1);
        endcase
    endtask

    task automatic check_write(input logic [REG_BITS-1:0] r, input logic [DATA_BITS-1:0] d);
        logic [REG_BITS+DATA_BITS-1:0] want;
        if (r == REG_BITS'(6)) begin
            // interrupt service lands between instructions
            assert (irq_writes < inta_seen)
                else stop_with_error("r6 written without an acknowledged interrupt");
            assert (d == DATA_BITS'(irq_writes + 1))
                else stop_with_error($sformatf("Mismatch at %0t: wr_data (r6) got %h expected %h",
                                               $time, d, DATA_BITS'(irq_writes + 1)));
            irq_writes++;
        end else begin
            assert (exp_q.size() > 0)
                else stop_with_error($sformatf("write to r%0d reported with none expected", r));
            want = exp_q.pop_front();
            assert (r == want[DATA_BITS +: REG_BITS])
                else stop_with_error($sformatf("Mismatch at %0t: wr_reg got %0d expected %0d",
                                               $time, r, want[DATA_BITS +: REG_BITS]));
            assert (d == want[DATA_BITS-1:0])
                else stop_with_error($sformatf("Mismatch at %0t: wr_data got %h expected %h",
                                               $time, d, want[DATA_BITS-1:0]));
        end
        observed[r] = d;
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        if (!reset) begin
            if (inta) begin
                assert (intr) else stop_with_error("inta pulsed with no interrupt request");
                inta_seen++;
            end
            if (wr_valid) begin
                check_write(wr_reg, wr_data);
            end
            assert (dut_i.seq_i.seq_assert_i.fail_count == 0)
                else stop_with_error("a protocol assertion on the sequencer failed");
        end
    end

    // interrupt requester, holds intr until it sees inta
    initial begin
        int gap;
        @(negedge reset);
        for (int k = 0; k < NUM_IRQS; k++) begin
            gap = 8 + ({$random(irq_seed)} % IRQ_GAP_MAX);
            repeat (gap) @(posedge clk);
            intr <= 1'b1;
            @(posedge clk);
            while (!inta) begin
                @(posedge clk);
            end
            intr <= 1'b0;
        end
    end

    initial begin
        int limit;
        @(negedge reset);
        limit = (num_vecs + NUM_IRQS) * ROUTINE_CYCLES + NUM_IRQS * (IRQ_GAP_MAX + 8)
                + DRAIN_CYCLES;
        repeat (limit) @(posedge clk);
        stop_with_error($sformatf("timeout: run did not finish within %0d cycles", limit));
    end

    initial begin
        int          credits;
        int          avail;
        int          idx;
        logic [31:0] rec;
        reset     = 1'b1;
        in_valid  = 1'b0;
        in_opcode = '0;
        in_rd     = '0;
        in_imm    = '0;
        intr      = 1'b0;
        for (int r = 0; r < NUM_REGS; r++) begin
            model[r]    = '0;
            observed[r] = '0;
        end
        $readmemh("tests/ucode_vectors.txt", vec_mem);
        num_vecs = vec_mem[0];
        assert (num_vecs > 0 && num_vecs <= MAX_VECS)
            else stop_with_error("vector file holds no usable instruction count");
        for (int i = 1; i <= num_vecs; i++) begin
            assert (vec_mem[i][16 +: REG_BITS] != REG_BITS'(6))
                else stop_with_error($sformatf("vector %0d uses r6, kept for interrupts", i));
        end
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        credits = QUEUE_DEPTH;
        idx = 1;
        while (idx <= num_vecs) begin
            @(posedge clk);
            avail = credits + int'(in_credit);
            assert (avail <= QUEUE_DEPTH)
                else stop_with_error("queue returned more credits than it has entries");
            if (avail > 0 && ({$random(gap_seed)} % 3) != 0) begin
                rec = vec_mem[idx];
                in_valid  <= 1'b1;
                in_opcode <= rec[31:24];
                in_rd     <= rec[16 +: REG_BITS];
                in_imm    <= rec[DATA_BITS-1:0];
                expect_instr(rec[31:24], rec[16 +: REG_BITS], rec[DATA_BITS-1:0]);
                credits = avail - 1;
                idx++;
            end else begin
                in_valid <= 1'b0;
                credits = avail;
            end
        end
        @(posedge clk);
        in_valid <= 1'b0;
        while (exp_q.size() != 0 || irq_writes != NUM_IRQS) begin
            @(posedge clk);
        end
        // quiet period, any stray write is caught by the monitor
        repeat (DRAIN_CYCLES) @(posedge clk);
        assert (inta_seen == NUM_IRQS)
            else stop_with_error($sformatf("saw %0d interrupt acknowledges for %0d requests",
                                           inta_seen, NUM_IRQS));
        for (int r = 0; r < NUM_REGS; r++) begin
            assert (observed[r] == vec_mem[num_vecs + 1 + r][DATA_BITS-1:0])
                else stop_with_error($sformatf("Mismatch at %0t: final r%0d got %h expected %h",
                                               $time, r, observed[r],
                                               vec_mem[num_vecs + 1 + r][DATA_BITS-1:0]));
        end
        if (dut_i.seq_i.seq_assert_i.fail_count == 0) begin
            $display("Everything OK");
            $finish;
        end else begin
            stop_with_error("protocol assertions failed during the run");
        end
    end

endmodule

/* tests/ucode_vectors.txt */
// word 0 is the instruction count, then one instruction per line: opcode(2) rd(2) imm(4)
// the last eight words are the expected final r0..r7, r6 counts the four interrupts
00000018
// ldi, addi, xori
01011234
010200ff
02010f0f
0302aaaa
// shift count 0 with upper imm bits set
040200f0
01030001
0403000f
// sum down from 5
01040005
05040000
// unknown opcode
7f01ffff
010500c3
040500f3
0200fff1
01040003
05040000
00020000
03012143
0201ffff
04010001
a5031234
// sum down with rd already zero
05040000
04020004
03030f0f
02050100
// expected final registers
00000006
0000fffe
0000a550
00008f0f
00000000
00000718
00000004
00000003
